// File: bench/mcl_patterns.txt
// memField readMode testSat magic ad proc loadHeld condSelVma diagRead diagSel
// then expected mboxReq cycle ctx heldOrPc diagData, as seen late in the same cycle
0 0 0 000 000 0123 0 1 1 0  0 00 00 000 00
7 0 0 000 000 0123 0 0 1 5  0 00 00 123 23
0 0 0 000 000 0123 0 0 0 5  0 00 00 123 00
8 0 0 000 000 0123 0 1 1 2  1 00 00 000 00
9 0 0 000 000 0123 0 0 1 2  1 20 00 123 20
a 0 0 000 000 0123 0 0 1 4  1 10 00 123 09
b 0 0 000 000 0123 0 0 1 2  1 24 00 123 24
c 0 0 000 000 0123 0 0 1 4  1 2c 00 123 0a
d 0 0 000 000 0123 0 0 1 2  1 04 00 123 04
e 0 0 000 000 0123 0 0 1 2  1 12 00 123 12
f 0 0 000 000 0123 0 0 1 2  1 28 00 123 28
2 0 0 000 000 0123 0 0 1 2  1 14 00 123 14
1 0 0 000 000 0123 0 0 1 2  0 04 00 123 04
1 1 0 000 000 0123 0 0 1 2  1 04 00 123 04
1 2 0 000 000 0123 0 0 1 2  0 12 00 123 12
1 3 0 000 000 0123 0 0 1 2  1 12 00 123 12
1 4 0 000 000 0123 0 0 1 2  1 04 00 123 04
1 5 0 000 000 0123 0 0 1 2  1 20 00 123 20
1 6 0 000 000 0123 0 0 1 2  1 20 00 123 20
1 7 0 000 000 0123 0 0 1 2  1 24 00 123 24
3 0 0 000 000 0123 0 0 1 2  0 2c 00 123 2c
3 0 1 000 000 0123 0 0 1 2  1 2c 00 123 2c
4 0 0 100 000 0123 0 0 1 2  1 12 00 123 12
6 0 0 060 000 0123 0 0 1 2  1 01 00 123 01
5 0 0 000 cb0 0123 0 0 1 4  1 0c 00 123 04
0 0 0 000 000 0123 1 1 1 3  0 30 16 000 16
6 0 0 100 001 4923 0 1 1 0  1 30 16 616 16
6 0 0 080 000 4923 0 1 1 1  1 20 12 616 18
8 0 0 000 041 4923 0 0 1 2  1 10 13 123 10
5 0 0 000 010 4923 1 1 1 3  1 20 13 616 13
0 0 0 000 000 0123 0 1 1 0  0 00 02 413 13
9 0 0 000 000 0123 0 1 1 1  1 00 02 413 10
0 0 0 000 000 0123 0 1 1 6  0 10 00 413 04
0 0 0 000 000 05a5 0 0 1 7  0 10 00 5a5 00
0 0 0 000 000 05a5 0 0 1 5  0 10 00 5a5 25
0 0 0 000 000 05a5 0 0 1 6  0 10 00 5a5 16
0 0 0 000 000 05a5 0 1 0 2  0 10 00 413 00

// File: bench/memControlTb.sv
`timescale 1ns/100ps
`include "mcl_settings.svh"

module memControlTb import mclPkg::*; ();

  localparam int ClkPeriod   = 100;
  localparam int ResetCycles = 8;
  localparam int NumPatterns = 37;
  // Ten stimulus fields, then five expected fields
  localparam int NumFields   = 15;
  localparam int ExpBase     = 10;

  logic                    clk;
  logic                    rstN;
  memFuncT                 memField;
  logic [2:0]              readMode;
  logic                    testSatisfied;
  logic [0:`MCL_MAGIC_W-1] magic;
  logic [1:`MCL_AD_W]      ad;
  procFlagsT               proc;
  logic                    loadHeld;
  logic                    condSelVma;
  logic                    diagRead;
  logic [2:0]              diagSel;
  logic                    mboxReq;
  cycleFlagsT              cycle;
  vmaCtxT                  ctx;
  heldT                    heldOrPc;
  logic [`MCL_DIAG_W-1:0]  diagData;

  logic [15:0] patMem [0:NumPatterns*NumFields-1];
  int          errorCount;

  memControl memControl_i (
    .clk           (clk),
    .rstN          (rstN),
    .memField      (memField),
    .readMode      (readMode),
    .testSatisfied (testSatisfied),
    .magic         (magic),
    .ad            (ad),
    .proc          (proc),
    .loadHeld      (loadHeld),
    .condSelVma    (condSelVma),
    .diagRead      (diagRead),
    .diagSel       (diagSel),
    .mboxReq       (mboxReq),
    .cycle         (cycle),
    .ctx           (ctx),
    .heldOrPc      (heldOrPc),
    .diagData      (diagData)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  task automatic applyPattern(input int idx);
    int base;
    base = idx * NumFields;
    memField      = memFuncT'(patMem[base][3:0]);
    readMode      = patMem[base + 1][2:0];
    testSatisfied = patMem[base + 2][0];
    magic         = patMem[base + 3][`MCL_MAGIC_W-1:0];
    ad            = patMem[base + 4][`MCL_AD_W-1:0];
    proc          = procFlagsT'(patMem[base + 5][14:0]);
    loadHeld      = patMem[base + 6][0];
    condSelVma    = patMem[base + 7][0];
    diagRead      = patMem[base + 8][0];
    diagSel       = patMem[base + 9][2:0];
  endtask

  // Registered outputs hold what earlier lines loaded
  task automatic checkOutputs(input int idx);
    int base;
    base = idx * NumFields + ExpBase;
    if (mboxReq !== patMem[base][0]) begin
      $display("CHECK FAILED line %0d: mboxReq got %h expected %h",
               idx + 1, mboxReq, patMem[base][0]);
      errorCount++;
    end
    if (cycle !== patMem[base + 1][5:0]) begin
      $display("CHECK FAILED line %0d: cycle got %h expected %h",
               idx + 1, cycle, patMem[base + 1][5:0]);
      errorCount++;
    end
    if (ctx !== patMem[base + 2][4:0]) begin
      $display("CHECK FAILED line %0d: ctx got %h expected %h",
               idx + 1, ctx, patMem[base + 2][4:0]);
      errorCount++;
    end
    if (heldOrPc !== patMem[base + 3][10:0]) begin
      $display("CHECK FAILED line %0d: heldOrPc got %h expected %h",
               idx + 1, heldOrPc, patMem[base + 3][10:0]);
      errorCount++;
    end
    if (diagData !== patMem[base + 4][`MCL_DIAG_W-1:0]) begin
      $display("CHECK FAILED line %0d: diagData got %h expected %h",
               idx + 1, diagData, patMem[base + 4][`MCL_DIAG_W-1:0]);
      errorCount++;
    end
  endtask

  initial begin
    clk           = 1'b0;
    rstN          = 1'b0;
    memField      = memNop;
    readMode      = '0;
    testSatisfied = 1'b0;
    magic         = '0;
    ad            = '0;
    proc          = '0;
    loadHeld      = 1'b0;
    condSelVma    = 1'b0;
    diagRead      = 1'b0;
    diagSel       = '0;
    errorCount    = 0;
    $readmemh("bench/mcl_patterns.txt", patMem);

    repeat (ResetCycles) @(posedge clk);
    #10;
    rstN = 1'b1;

    // Drive just after the edge, sample late in the cycle
    for (int i = 0; i < NumPatterns; i++) begin
      applyPattern(i);
      #80;
      checkOutputs(i);
      @(posedge clk);
      #10;
    end

    $display("Checked %0d patterns, %0d errors", NumPatterns, errorCount);
    if (errorCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #((NumPatterns + 20) * ClkPeriod);
    $display("Timeout: the pattern run did not complete in the expected time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: build.f
+incdir+logic
logic/mclPkg.sv
logic/memFuncDecode.sv
logic/cycleControl.sv
logic/vmaContext.sv
logic/heldStatus.sv
logic/memControl.sv
bench/memControlTb.sv

// File: logic/cycleControl.sv
`timescale 1ns/100ps
`include "mcl_settings.svh"

module cycleControl import mclPkg::*; (
  input  logic                        clk,
  input  logic                        rstN,
  input  memStrobesT                  strobes,
  input  memFuncT                     memField,
  input  logic [2:0]                  readMode,
  input  logic [0:`MCL_MAGIC_W-1]     magic,
  input  logic [1:`MCL_AD_W]          ad,
  output cycleFlagsT                  cycle
);

  cycleFlagsT nextCycle;

  always_comb begin
    nextCycle = '0;

    if (strobes.isAread) begin
      nextCycle.loadAr  = readMode[2];
      nextCycle.pause   = (readMode == 3'd7);
      nextCycle.write   = (readMode == 3'd3) || (readMode == 3'd6) || (readMode == 3'd7);
      nextCycle.loadArx = (readMode == 3'd1);
      nextCycle.fetch   = (readMode == 3'd1);
    end else if (strobes.isEaCalc) begin
      {nextCycle.loadAr, nextCycle.loadArx, nextCycle.pause, nextCycle.write} = magic[0:3];
    end else if (strobes.isAdFunc) begin
      {nextCycle.loadAr, nextCycle.loadArx, nextCycle.pause, nextCycle.write} = ad[1:4];
    end else if (strobes.isRegFunc) begin
      nextCycle.regFunc = magic[0];
    end else if (strobes.isCondFetch) begin
      nextCycle.loadArx = 1'b1;
      nextCycle.fetch   = 1'b1;
    end else if (memField == memBWrite) begin
      nextCycle.write = 1'b1;
    end else if (strobes.isPlain) begin
      // Fixed cycles
      nextCycle.loadAr  = (memField == memLoadAr) || (memField == memRwCycle) ||
                          (memField == memRpwCycle) || (memField == memLoadArPause);
      nextCycle.loadArx = (memField == memLoadArx) || (memField == memUncondFetch) ||
                          (memField == memLoadArxWrite);
      nextCycle.pause   = (memField == memRpwCycle) || (memField == memLoadArPause);
      nextCycle.write   = (memField == memRwCycle) || (memField == memRpwCycle) ||
                          (memField == memWrite) || (memField == memLoadArxWrite);
      nextCycle.fetch   = (memField == memUncondFetch);
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cycle <= '0;
    end else if (strobes.reqEn) begin
      cycle <= nextCycle;
    end
  end

endmodule

// File: logic/heldStatus.sv
`timescale 1ns/100ps
`include "mcl_settings.svh"

module heldStatus import mclPkg::*; (
  input  logic                   clk,
  input  logic                   rstN,
  input  cycleFlagsT             cycle,
  input  vmaCtxT                 ctx,
  input  procFlagsT              proc,
  input  logic                   loadHeld,
  input  logic                   condSelVma,
  input  logic                   diagRead,
  input  logic [2:0]             diagSel,
  output heldT                   heldOrPc,
  output logic [`MCL_DIAG_W-1:0] diagData
);

  heldT held;
  logic vmaRead;
  logic storeAr;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      held <= '0;
    end else if (loadHeld) begin
      held <= '{cycle: cycle, ctx: ctx};
    end
  end

  assign heldOrPc = condSelVma ? held : heldT'(proc.pcFlags);

  // Store is a paused write with neither AR nor ARX loading
  assign vmaRead = cycle.loadAr | cycle.loadArx;
  assign storeAr = cycle.pause & cycle.write & ~cycle.loadAr & ~cycle.loadArx;

  always_comb begin
    diagData = '0;
    if (diagRead) begin
      case (diagSel)
        3'd0: diagData = held[5:0];
        3'd1: diagData = {1'b0, held[10:6]};
        3'd2: diagData = cycle;
        3'd3: diagData = {1'b0, ctx};
        3'd4: diagData = {2'b00, vmaRead, storeAr, cycle.loadAr, cycle.loadArx};
        3'd5: diagData = proc.pcFlags[5:0];
        3'd6: diagData = {1'b0, proc.pcFlags[10:6]};
        default: diagData = '0;
      endcase
    end
  end

endmodule

// File: logic/mclPkg.sv
package mclPkg;

  // Microword memory function field
  typedef enum logic [3:0] {
    memNop          = 4'd0,
    memARead        = 4'd1,
    memBWrite       = 4'd2,
    memCondFetch    = 4'd3,
    memRegFunc      = 4'd4,
    memAdFunc       = 4'd5,
    memEaCalc       = 4'd6,
    memRestoreVma   = 4'd7,
    memLoadAr       = 4'd8,
    memLoadArx      = 4'd9,
    memRwCycle      = 4'd10,
    memRpwCycle     = 4'd11,
    memWrite        = 4'd12,
    memUncondFetch  = 4'd13,
    memLoadArPause  = 4'd14,
    memLoadArxWrite = 4'd15
  } memFuncT;

  typedef struct packed {
    logic isAread;
    logic isAdFunc;
    logic isEaCalc;
    logic isRegFunc;
    logic isCondFetch;
    // Fixed cycle codes 8 to 15
    logic isPlain;
    logic reqEn;
    logic loadVma;
  } memStrobesT;

  typedef struct packed {
    logic loadAr;
    logic loadArx;
    logic pause;
    logic write;
    logic fetch;
    logic regFunc;
  } cycleFlagsT;

  typedef struct packed {
    logic user;
    logic public;
    logic previous;
    logic extended;
    logic adrErr;
  } vmaCtxT;

  typedef struct packed {
    cycleFlagsT cycle;
    vmaCtxT     ctx;
  } heldT;

  typedef struct packed {
    logic        user;
    logic        public;
    logic        pxctPrev;
    logic        sectionNonZero;
    logic [10:0] pcFlags;
  } procFlagsT;

endpackage

// File: logic/mcl_settings.svh
`ifndef MCL_SETTINGS_SVH
`define MCL_SETTINGS_SVH

// AD bus slice, numbered 1 to 12
`define MCL_AD_W 12

// Microword magic number field, numbered 0 to 8
`define MCL_MAGIC_W 9

// Diagnostic readback slice
`define MCL_DIAG_W 6

`endif

// File: logic/memControl.sv
`timescale 1ns/100ps
`include "mcl_settings.svh"

module memControl import mclPkg::*; (
  input  logic                    clk,
  input  logic                    rstN,
  input  memFuncT                 memField,
  input  logic [2:0]              readMode,
  input  logic                    testSatisfied,
  input  logic [0:`MCL_MAGIC_W-1] magic,
  input  logic [1:`MCL_AD_W]      ad,
  input  procFlagsT               proc,
  input  logic                    loadHeld,
  input  logic                    condSelVma,
  input  logic                    diagRead,
  input  logic [2:0]              diagSel,
  output logic                    mboxReq,
  output cycleFlagsT              cycle,
  output vmaCtxT                  ctx,
  output heldT                    heldOrPc,
  output logic [`MCL_DIAG_W-1:0]  diagData
);

  memStrobesT strobes;

  assign mboxReq = strobes.reqEn;

  memFuncDecode memFuncDecode_i (
    .memField      (memField),
    .readMode      (readMode),
    .testSatisfied (testSatisfied),
    .strobes       (strobes)
  );

  cycleControl cycleControl_i (
    .clk      (clk),
    .rstN     (rstN),
    .strobes  (strobes),
    .memField (memField),
    .readMode (readMode),
    .magic    (magic),
    .ad       (ad),
    .cycle    (cycle)
  );

  vmaContext vmaContext_i (
    .clk     (clk),
    .rstN    (rstN),
    .strobes (strobes),
    .ad      (ad),
    .proc    (proc),
    .ctx     (ctx)
  );

  heldStatus heldStatus_i (
    .clk        (clk),
    .rstN       (rstN),
    .cycle      (cycle),
    .ctx        (ctx),
    .proc       (proc),
    .loadHeld   (loadHeld),
    .condSelVma (condSelVma),
    .diagRead   (diagRead),
    .diagSel    (diagSel),
    .heldOrPc   (heldOrPc),
    .diagData   (diagData)
  );

endmodule

// File: logic/memFuncDecode.sv
`timescale 1ns/100ps

module memFuncDecode import mclPkg::*; (
  input  memFuncT    memField,
  input  logic [2:0] readMode,
  input  logic       testSatisfied,
  output memStrobesT strobes
);

  logic readModeIdle;

  // Read modes 0 and 2 need no memory cycle
  assign readModeIdle = (readMode == 3'd0) || (readMode == 3'd2);

  always_comb begin
    strobes = '0;

    strobes.isAread     = (memField == memARead);
    strobes.isAdFunc    = (memField == memAdFunc);
    strobes.isEaCalc    = (memField == memEaCalc);
    strobes.isRegFunc   = (memField == memRegFunc);
    strobes.isCondFetch = (memField == memCondFetch);
    strobes.isPlain     = memField[3];

    case (memField)
      memNop,
      memRestoreVma: begin
        strobes.reqEn = 1'b0;
      end
      memARead: begin
        strobes.reqEn = ~readModeIdle;
      end
      memCondFetch: begin
        strobes.reqEn = testSatisfied;
      end
      default: begin
        strobes.reqEn = 1'b1;
      end
    endcase

    // VMA is loaded for address-forming functions and all fixed cycles
    strobes.loadVma = strobes.isAread |
                      strobes.isAdFunc |
                      strobes.isEaCalc |
                      strobes.isPlain;
  end

endmodule

// File: logic/vmaContext.sv
`timescale 1ns/100ps
`include "mcl_settings.svh"

module vmaContext import mclPkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  memStrobesT          strobes,
  input  logic [1:`MCL_AD_W]  ad,
  input  procFlagsT           proc,
  output vmaCtxT              ctx
);

  vmaCtxT nextCtx;
  logic   adHighBad;

  // Extended address must have a clean section field and bit 12 set
  assign adHighBad = (ad[6:11] != '0) | ~ad[`MCL_AD_W];

  always_comb begin
    nextCtx = '0;

    if (strobes.isAdFunc) begin
      nextCtx.user     = ad[5];
      nextCtx.public   = ad[6];
      nextCtx.previous = ad[7];
      nextCtx.extended = ad[8];
    end else begin
      nextCtx.user     = proc.user;
      nextCtx.public   = proc.public;
      nextCtx.previous = proc.pxctPrev;
      nextCtx.extended = proc.sectionNonZero;
    end

    nextCtx.adrErr = nextCtx.extended & ~strobes.isAdFunc & adHighBad;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ctx <= '0;
    end else if (strobes.loadVma) begin
      ctx <= nextCtx;
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Compile and run the memControl testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  -f build.f --top-module memControlTb \
  -Mdir obj_dir -o memControlSim

./obj_dir/memControlSim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "Run reported failure, see sim.log"
  exit 1
fi

echo "Run completed, see sim.log"
